//--- dly_code_loader.sv
////////////////////////////////////////////////////////////
// delay code loader
// takes one setting per valid/ready transfer, walks the
// lane's gray code one bit per cycle, then commits coarse
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dly_code_loader import dly_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         cfg_valid,
  input  dly_setting_t cfg,
  output logic         cfg_ready,
  output coarse_t      coarse [NUM_LANES],
  output gray_code_t   gray [NUM_LANES]
);

  loader_state_t state;
  dly_setting_t  req;        // latched request
  gray_code_t    tgt_gray;   // target fine code in gray
  gray_code_t    cur_gray;   // addressed lane's current code
  gray_code_t    next_gray;  // one step toward the target
  fine_t         cur_bin;

  function automatic gray_code_t bin2gray(input fine_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic fine_t gray2bin(input gray_code_t g);
    fine_t b;
    b[2] = g[2];
    for (int i = 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign cfg_ready = (state == IDLE);

  // binary neighbours map to gray codes one bit apart
  assign cur_gray  = gray[req.lane];
  assign cur_bin   = gray2bin(cur_gray);
  assign next_gray = bin2gray((cur_bin < req.fine) ? cur_bin + 3'd1 : cur_bin - 3'd1);

  always_ff @(posedge clk) begin
    if (cfg_valid && cfg_ready) begin
      req      <= cfg;
      tgt_gray <= bin2gray(cfg.fine);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      for (int i = 0; i < NUM_LANES; i++) begin
        coarse[i] <= '0;
        gray[i]   <= '0;
      end
    end else begin
      case (state)
        IDLE: begin
          if (cfg_valid) state <= STEP;  // accepted, ready drops next cycle
        end
        STEP: begin
          if (cur_gray != tgt_gray) gray[req.lane] <= next_gray;
          if (cur_gray == tgt_gray || next_gray == tgt_gray) state <= COMMIT;
        end
        COMMIT: begin
          coarse[req.lane] <= req.coarse;  // coarse moves once fine has settled
          state            <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // interpolator codes may only ever move one bit per cycle
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_step_chk
    a_one_bit_step: assert property (@(posedge clk) disable iff (rst)
      $onehot0(gray[i] ^ $past(gray[i])));
  end

endmodule

`default_nettype wire

//--- dly_interp_lane.sv
////////////////////////////////////////////////////////////
// one delay lane
// coarse delay picks a beat from the history, the gray code
// gives a thermometer whose weight is the fine sample shift
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dly_interp_lane import dly_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        beat_en,
  input  phase_word_t din,
  input  coarse_t     coarse,
  input  gray_code_t  gray,
  output phase_word_t dout
);

  phase_word_t             hist [MAX_COARSE+1];  // hist[0] is the previous beat
  therm_t                  therm;
  fine_t                   fine_shift;
  phase_word_t             newer;    // beat at the coarse depth
  phase_word_t             older;    // the beat before it
  logic [2*PHASES-1:0]     pair;
  phase_word_t             shifted;

  ////////////////////////////////////////////////////////////
  // fine code decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (gray)
      3'b000:  therm = 7'b000_0000;
      3'b001:  therm = 7'b000_0001;
      3'b011:  therm = 7'b000_0011;
      3'b010:  therm = 7'b000_0111;
      3'b110:  therm = 7'b000_1111;
      3'b111:  therm = 7'b001_1111;
      3'b101:  therm = 7'b011_1111;
      3'b100:  therm = 7'b111_1111;
      default: therm = 7'b000_0000;
    endcase
  end

  assign fine_shift = fine_t'($countones(therm));  // thermometer weight

  ////////////////////////////////////////////////////////////
  // sample selection
  ////////////////////////////////////////////////////////////

  assign newer = (coarse == '0) ? din : hist[coarse - 3'd1];
  assign older = hist[coarse];

  // older samples sit below newer ones, the window slides back by fine
  assign pair    = {newer, older};
  assign shifted = phase_word_t'(pair >> (PHASES - fine_shift));

  always_ff @(posedge clk) begin
    if (rst) begin
      dout <= '0;
      for (int i = 0; i <= MAX_COARSE; i++) begin
        hist[i] <= '0;
      end
    end else if (beat_en) begin
      dout    <= shifted;
      hist[0] <= din;
      for (int i = 1; i <= MAX_COARSE; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // the weight only means a delay if the ones start at bit 0
  // and it may only move one sample per cycle as the code steps
  a_therm_contig: assert property (@(posedge clk) disable iff (rst)
    (therm & (therm + 1'b1)) == '0 && $onehot0(therm ^ $past(therm)));

endmodule

`default_nettype wire

//--- dly_lane_collector.sv
////////////////////////////////////////////////////////////
// lane collector
// packs the lane words into one bundle and drives the
// output stream through a two-entry skid buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dly_lane_collector import dly_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         lane_valid,
  input  phase_word_t  lane_words [NUM_LANES],
  output logic         not_full,
  output logic         out_valid,
  output lane_bundle_t out_data,
  input  logic         out_ready
);

  lane_bundle_t bundle;
  lane_bundle_t skid_data;
  logic         skid_valid;
  logic         drain;
  logic [1:0]   occ_next;  // entries held after this edge

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      bundle.word[i] = lane_words[i];
    end
  end

  assign drain    = out_valid && out_ready;
  assign occ_next = 2'(out_valid) + 2'(skid_valid) + 2'(lane_valid) - 2'(drain);

  // one more beat is always in flight in the lane registers
  assign not_full = (occ_next <= 2'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (!out_valid || out_ready) begin
      if (skid_valid) begin
        out_valid  <= 1'b1;        // skid moves up
        skid_valid <= lane_valid;
      end else begin
        out_valid  <= lane_valid;
      end
    end else if (lane_valid) begin
      skid_valid <= 1'b1;          // head stalled, park the beat
    end
  end

  always_ff @(posedge clk) begin
    if (!out_valid || out_ready) begin
      if (skid_valid) begin
        out_data <= skid_data;
        if (lane_valid) skid_data <= bundle;
      end else if (lane_valid) begin
        out_data <= bundle;
      end
    end else if (lane_valid && !skid_valid) begin
      skid_data <= bundle;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_hold_data: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  // in_ready upstream must never let a beat arrive with both entries stuck
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    !(lane_valid && skid_valid && out_valid && !out_ready));

endmodule

`default_nettype wire

//--- dly_pkg.sv
////////////////////////////////////////////////////////////
// shared definitions for the per-lane IO delay line model
// widths, stream and config structs, loader FSM states
// every design file pulls this in with a wildcard import
////////////////////////////////////////////////////////////

`default_nettype none

package dly_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int NUM_LANES  = 4;  // delay lanes in the bundle
  localparam int PHASES     = 8;  // samples per beat
  localparam int MAX_COARSE = 7;  // deepest coarse delay, in beats

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [PHASES-1:0] phase_word_t;  // bit 0 is the earliest sample
  typedef logic [2:0]        gray_code_t;   // interpolator code, gray order
  typedef logic [6:0]        therm_t;       // interpolator weight
  typedef logic [2:0]        coarse_t;      // whole beats
  typedef logic [2:0]        fine_t;        // samples, plain binary
  typedef logic [1:0]        lane_id_t;

  // one configuration request, 8 bits
  typedef struct packed {
    lane_id_t lane;
    coarse_t  coarse;
    fine_t    fine;
  } dly_setting_t;

  // one phase word per lane, lane 0 in the low byte
  typedef struct packed {
    phase_word_t [NUM_LANES-1:0] word;
  } lane_bundle_t;

  // code loader FSM
  typedef enum logic [1:0] {
    IDLE,
    STEP,
    COMMIT
  } loader_state_t;

endpackage

`default_nettype wire

//--- dly_top.sv
////////////////////////////////////////////////////////////
// delay line top level
// config port feeds the code loader, the input stream runs
// through the lanes and leaves via the collector
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module dly_top import dly_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         cfg_valid,
  input  dly_setting_t cfg,
  output logic         cfg_ready,
  input  logic         in_valid,
  input  lane_bundle_t in_data,
  output logic         in_ready,
  output logic         out_valid,
  output lane_bundle_t out_data,
  input  logic         out_ready
);

  coarse_t     lane_coarse [NUM_LANES];
  gray_code_t  lane_gray [NUM_LANES];
  phase_word_t lane_dout [NUM_LANES];
  logic        beat_en;
  logic        lane_valid;  // lane registers hold a new beat
  logic        not_full;

  assign in_ready = not_full;
  assign beat_en  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) lane_valid <= 1'b0;
    else     lane_valid <= beat_en;  // follows the lane register by one
  end

  dly_code_loader u_loader (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .cfg_ready (cfg_ready),
    .coarse    (lane_coarse),
    .gray      (lane_gray)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    dly_interp_lane u_lane (
      .clk     (clk),
      .rst     (rst),
      .beat_en (beat_en),
      .din     (in_data.word[i]),
      .coarse  (lane_coarse[i]),
      .gray    (lane_gray[i]),
      .dout    (lane_dout[i])
    );
  end

  dly_lane_collector u_collector (
    .clk        (clk),
    .rst        (rst),
    .lane_valid (lane_valid),
    .lane_words (lane_dout),
    .not_full   (not_full),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

//--- dly_tb_vectors.svh
////////////////////////////////////////////////////////////
// test vectors for the delay line testbench
// one row per delay setting, applied and streamed in order
////////////////////////////////////////////////////////////

`ifndef DLY_TB_VECTORS_SVH
`define DLY_TB_VECTORS_SVH

// columns: lane, coarse beats, fine samples, beat count,
// pulse (1 walking pulse, 0 random words), random out_ready, overlap
typedef struct packed {
  lane_id_t lane;
  coarse_t  coarse;
  fine_t    fine;
  logic [7:0] beats;
  logic     pulse;
  logic     rdy_rand;
  logic     overlap;   // a decoy request goes first, this one waits behind it
} vec_row_t;

localparam int NUM_ROWS = 16;

localparam vec_row_t VEC_TABLE [NUM_ROWS] = '{
  '{2'd2, 3'd7, 3'd0, 8'd16, 1'b0, 1'b0, 1'b0},  // deepest coarse delay on reset history
  '{2'd0, 3'd0, 3'd0, 8'd16, 1'b0, 1'b0, 1'b0},  // zero delay
  '{2'd0, 3'd1, 3'd0, 8'd12, 1'b0, 1'b0, 1'b0},  // coarse only
  '{2'd1, 3'd3, 3'd0, 8'd12, 1'b0, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd1, 8'd10, 1'b1, 1'b0, 1'b0},  // fine sweep on a pulse
  '{2'd3, 3'd0, 3'd2, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd3, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd4, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd5, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd6, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd3, 3'd0, 3'd7, 8'd10, 1'b1, 1'b0, 1'b0},
  '{2'd0, 3'd2, 3'd5, 8'd24, 1'b0, 1'b1, 1'b0},  // mixed, back-pressure
  '{2'd1, 3'd5, 3'd3, 8'd24, 1'b0, 1'b1, 1'b0},
  '{2'd2, 3'd0, 3'd6, 8'd20, 1'b0, 1'b1, 1'b1},
  '{2'd3, 3'd4, 3'd0, 8'd16, 1'b1, 1'b0, 1'b1},
  '{2'd0, 3'd7, 3'd7, 8'd32, 1'b0, 1'b1, 1'b0}
};

`endif

//--- tb_dly_top.sv
////////////////////////////////////////////////////////////
// testbench for the delay line top level
// runs the vector table through the config and stream ports
// and checks each output beat against a serial sample model
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_dly_top import dly_pkg::*;;

  `include "dly_tb_vectors.svh"

  localparam int MAX_LOG = 1024;  // beats kept by the sample model

  logic         clk = 1'b0;
  logic         rst;
  logic         cfg_valid;
  dly_setting_t cfg;
  logic         cfg_ready;
  logic         in_valid;
  lane_bundle_t in_data;
  logic         in_ready;
  logic         out_valid;
  lane_bundle_t out_data;
  logic         out_ready;
  logic         rdy_random;
  int           cycle_cnt = 0;
  int           mismatch_cnt = 0;
  int           other_cnt = 0;
  int           acc_beats = 0;
  phase_word_t  beat_log [NUM_LANES][MAX_LOG];  // every accepted input word
  coarse_t      cur_coarse [NUM_LANES];
  fine_t        cur_fine [NUM_LANES];
  lane_bundle_t exp_q [$];
  int           acc_q [$];                      // acceptance cycle per beat
  logic         hold_valid = 1'b0;
  lane_bundle_t hold_data;

  dly_top UUT (
    .clk       (clk),
    .rst       (rst),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .cfg_ready (cfg_ready),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  always @(posedge clk) begin
    if (rdy_random) out_ready <= ($urandom_range(0, 1) == 1);
    else            out_ready <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // sample model
  ////////////////////////////////////////////////////////////

  // output sample n is input sample n - (coarse*8 + fine), zero before the start
  function automatic phase_word_t expect_word(input int k, input int b);
    phase_word_t w;
    int          d;
    int          n;
    d = int'(cur_coarse[k]) * PHASES + int'(cur_fine[k]);
    for (int j = 0; j < PHASES; j++) begin
      n = b * PHASES + j - d;
      w[j] = (n < 0) ? 1'b0 : beat_log[k][n / PHASES][n % PHASES];
    end
    return w;
  endfunction

  task automatic record_beat(input lane_bundle_t bnd);
    lane_bundle_t e;
    for (int k = 0; k < NUM_LANES; k++) begin
      beat_log[k][acc_beats] = bnd.word[k];
      e.word[k] = expect_word(k, acc_beats);
    end
    exp_q.push_back(e);
    acc_q.push_back(cycle_cnt);
    acc_beats++;
  endtask

  ////////////////////////////////////////////////////////////
  // config and stream drivers
  ////////////////////////////////////////////////////////////

  task automatic offer_setting(input dly_setting_t s);
    cfg_valid <= 1'b1;
    cfg       <= s;
    do @(posedge clk); while (!cfg_ready);  // transfer on this edge
  endtask

  // count the cycles with cfg_ready low, at least one per gray step plus commit
  task automatic await_loader(input lane_id_t lane, input coarse_t c, input fine_t f);
    int busy;
    int min_busy;
    busy     = 0;
    min_busy = ((f > cur_fine[lane]) ? int'(f) - int'(cur_fine[lane])
                                     : int'(cur_fine[lane]) - int'(f)) + 1;
    @(posedge clk);
    while (!cfg_ready) begin
      busy++;
      @(posedge clk);
    end
    assert (busy >= min_busy && busy <= 8) else begin
      other_cnt++;
      $display("loader stayed busy for %0d cycles, expected %0d to 8", busy, min_busy);
    end
    cur_coarse[lane] = c;
    cur_fine[lane]   = f;
  endtask

  task automatic configure(input vec_row_t r);
    dly_setting_t s;
    dly_setting_t decoy;
    s.lane   = r.lane;
    s.coarse = r.coarse;
    s.fine   = r.fine;
    if (r.overlap) begin
      decoy        = s;
      decoy.coarse = '0;
      decoy.fine   = ~r.fine;
      offer_setting(decoy);
      cfg <= s;  // held with valid high while the loader is busy
      await_loader(decoy.lane, decoy.coarse, decoy.fine);
    end else begin
      offer_setting(s);
    end
    cfg_valid <= 1'b0;
    await_loader(s.lane, s.coarse, s.fine);
  endtask

  task automatic stream_row(input vec_row_t r);
    lane_bundle_t bnd;
    for (int b = 0; b < int'(r.beats); b++) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        bnd.word[k] = r.pulse ? phase_word_t'(1 << ((b + k) % PHASES)) : phase_word_t'($urandom);
      end
      in_valid <= 1'b1;
      in_data  <= bnd;
      do @(posedge clk); while (!in_ready);
      record_beat(bnd);
    end
    in_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);  // drain before the next setting
  endtask

  ////////////////////////////////////////////////////////////
  // output checker
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    lane_bundle_t exp_b;
    int           acc;
    if (!rst) begin
      if (hold_valid) begin
        assert (out_valid && out_data == hold_data) else begin
          other_cnt++;
          $display("output beat dropped or changed while it waited for out_ready");
        end
      end
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else begin
          other_cnt++;
          $display("output beat arrived with no accepted beat left to match");
        end
        if (exp_q.size() != 0) begin
          exp_b = exp_q.pop_front();
          acc   = acc_q.pop_front();
          assert (out_data == exp_b) else begin
            mismatch_cnt++;
            $display("Mismatch out_data: expected %h, got %h", exp_b, out_data);
          end
          if (!rdy_random) begin
            assert (cycle_cnt - acc == 2) else begin
              mismatch_cnt++;
              $display("Mismatch latency: expected %h, got %h", 2, cycle_cnt - acc);
            end
          end
        end
      end
      hold_valid = out_valid && !out_ready;
      hold_data  = out_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hd07997bf));
    rst        = 1'b1;
    cfg_valid  = 1'b0;
    cfg        = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    rdy_random = 1'b0;
    for (int k = 0; k < NUM_LANES; k++) begin
      cur_coarse[k] = '0;
      cur_fine[k]   = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (cfg_ready && in_ready && !out_valid) else begin
      other_cnt++;
      $display("handshake outputs are not in their reset state");
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      rdy_random <= VEC_TABLE[i].rdy_rand;
      configure(VEC_TABLE[i]);
      stream_row(VEC_TABLE[i]);
    end
    repeat (4) @(posedge clk);  // room for a stray extra beat
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    int limit;
    limit = 2000;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit += int'(VEC_TABLE[i].beats) * 4;
    end
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
dly_pkg.sv
dly_code_loader.sv
dly_interp_lane.sv
dly_lane_collector.sv
dly_top.sv
tb_dly_top.sv
